// File: Bender.yml
package:
  name: rv_ctrl

sources:
  - files:
      - src/rv_ctrl_pkg.sv
      - src/instr_decoder.sv
      - src/decode_buffer.sv
      - src/multicycle_seq.sv
      - src/rv_ctrl_top.sv
  - target: simulation
    files:
      - sim/rv_ctrl_chk.sv
      - sim/tb_rv_ctrl.sv

// File: compile.f
src/rv_ctrl_pkg.sv
src/instr_decoder.sv
src/decode_buffer.sv
src/multicycle_seq.sv
src/rv_ctrl_top.sv
sim/rv_ctrl_chk.sv
sim/tb_rv_ctrl.sv

// File: sim/rv_ctrl_chk.sv
`timescale 1ns/1ps

module rv_ctrl_chk import rv_ctrl_pkg::*; (
    input logic          clk,
    input logic          rst_n,
    input t_decode_state state,
    input logic          buf_valid,
    input logic          pop,
    input logic          reg_write,
    input logic          mem_write
);

    int fail_cnt = 0;   // Failed assertions so far

    a_reg_write_wb: assert property (
        @(posedge clk) disable iff (!rst_n) reg_write |-> state == WB
    ) else begin
        fail_cnt++;
        $error("reg_write high outside WB");
    end

    a_mem_write_mem: assert property (
        @(posedge clk) disable iff (!rst_n) mem_write |-> state == MEM
    ) else begin
        fail_cnt++;
        $error("mem_write high outside MEM");
    end

    a_decode_to_exec: assert property (
        @(posedge clk) disable iff (!rst_n) state == DECODE |=> state == EXECUTE
    ) else begin
        fail_cnt++;
        $error("DECODE not followed by EXECUTE");
    end

    a_pop_in_fetch: assert property (
        @(posedge clk) disable iff (!rst_n) pop |-> (state == FETCH && buf_valid)
    ) else begin
        fail_cnt++;
        $error("pop outside FETCH or from an empty buffer");
    end

endmodule

bind multicycle_seq rv_ctrl_chk u_chk (
    .clk       (clk),
    .rst_n     (rst_n),
    .state     (state),
    .buf_valid (buf_valid),
    .pop       (pop),
    .reg_write (reg_write),
    .mem_write (mem_write)
);

// File: sim/tb_rv_ctrl.sv
`timescale 1ns/1ps

module tb_rv_ctrl import rv_ctrl_pkg::*; ();

    localparam int MAX_ROWS    = 64;
    localparam int WAIT_LIMIT  = 200;    // Cycles allowed for one handshake
    localparam int DRAIN_LIMIT = 2000;

    logic                 clk;
    logic                 rst_n;
    logic [INSTR_W-1:0]   instruction;
    logic                 instr_valid;
    logic                 alu_zero;
    logic                 alu_slt;
    logic                 instr_ready;
    t_decode_state        state;
    t_mnemonic            op;
    logic [REG_IDX_W-1:0] rs1;
    logic [REG_IDX_W-1:0] rs2;
    logic [REG_IDX_W-1:0] rd;
    t_alu_op              alu_ctrl;
    logic                 alu_signed;
    t_src_a               alu_src_a;
    t_src_b               alu_src_b;
    t_imm_kind            imm_src;
    logic                 result_src;
    logic                 pc_src;
    logic                 pc_update;
    logic                 mem_write;
    logic                 reg_write;

    // Stimulus table with one row per word
    string      t_name  [MAX_ROWS];
    logic [31:0] t_word [MAX_ROWS];
    logic [1:0] t_flags [MAX_ROWS];   // {alu_zero, alu_slt}
    t_mnemonic  t_op    [MAX_ROWS];
    t_alu_op    t_alu   [MAX_ROWS];
    bit         t_sgn   [MAX_ROWS];
    bit         t_pc    [MAX_ROWS];
    t_src_a     t_sa    [MAX_ROWS];
    t_src_b     t_sb    [MAX_ROWS];
    t_imm_kind  t_imm   [MAX_ROWS];
    string      t_path  [MAX_ROWS];   // States seen from DECODE back to FETCH
    bit         t_wr    [MAX_ROWS];
    int         n_rows = 0;

    int                   q_idx [$];  // Accepted words in order
    logic [REG_IDX_W-1:0] q_rs1 [$];
    logic [REG_IDX_W-1:0] q_rs2 [$];
    logic [REG_IDX_W-1:0] q_rd  [$];

    logic [31:0]          lfsr = 32'h1698_f4aa;
    int                   drv_idx;
    logic [REG_IDX_W-1:0] drv_rs1;
    logic [REG_IDX_W-1:0] drv_rs2;
    logic [REG_IDX_W-1:0] drv_rd;
    logic [1:0]           want_flags = 2'b00;
    string                cur_name = "none";
    int                   cur;
    bit                   active = 1'b0;
    string                path;
    int                   rw_cnt;
    int                   mw_cnt;
    int                   acc_cnt = 0;
    int                   pop_cnt = 0;
    int                   done_cnt = 0;
    bit                   saw_full = 1'b0;
    int                   mism_errs = 0;
    int                   other_errs = 0;
    int                   timeouts = 0;
    int                   total_errs;

    rv_ctrl_top u_dut (.*);

    always #2 clk = ~clk;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // Taps 32, 22, 2, 1
    endfunction

    task automatic take_bits(input int n, output logic [31:0] bits);
        int k;
        bits = '0;
        for (k = 0; k < n; k++) begin
            lfsr = lfsr_next(lfsr);
            bits = {bits[30:0], lfsr[0]};
        end
    endtask

    function automatic bit branch_taken(input t_mnemonic m, input logic z, input logic s);
        case (m)
            OP_BEQ:           return z;
            OP_BNE:           return !z;
            OP_BLT, OP_BLTU:  return s;
            OP_BGE, OP_BGEU:  return !s;
            default:          return 1'b0;
        endcase
    endfunction

    task automatic log_mismatch(input string field, input logic [31:0] exp,
                                input logic [31:0] act);
        $display("ERR %s %s: expected %0h, actual %0h", cur_name, field, exp, act);
        mism_errs++;
    endtask

    task automatic add_row(input string nm, input logic [31:0] word, input logic [1:0] flags,
                           input t_mnemonic m, input t_alu_op alu, input bit sgn, input bit pc,
                           input string cls);
        t_name[n_rows]  = nm;
        t_word[n_rows]  = word;
        t_flags[n_rows] = flags;
        t_op[n_rows]    = m;
        t_alu[n_rows]   = alu;
        t_sgn[n_rows]   = sgn;
        t_pc[n_rows]    = pc;
        t_sa[n_rows]    = SRC_A_REG;
        t_sb[n_rows]    = SRC_B_IMM;
        t_imm[n_rows]   = IMM_I;
        t_path[n_rows]  = "DEW";
        t_wr[n_rows]    = 1'b1;
        case (cls)
            "R":   t_sb[n_rows] = SRC_B_REG;
            "L":   t_path[n_rows] = "DEMW";
            "LUI": t_imm[n_rows] = IMM_U;
            "S": begin
                t_imm[n_rows]  = IMM_S;
                t_path[n_rows] = "DEM";
                t_wr[n_rows]   = 1'b0;
            end
            "AUI": begin
                t_sa[n_rows]  = SRC_A_PC;
                t_imm[n_rows] = IMM_U;
            end
            "B", "JAL": begin
                t_sb[n_rows]   = SRC_B_REG;
                t_imm[n_rows]  = (cls == "B") ? IMM_B : IMM_J;
                t_path[n_rows] = "DE";
                t_wr[n_rows]   = 1'b0;
            end
            "JALR": begin
                t_sb[n_rows]  = SRC_B_REG;
                t_imm[n_rows] = IMM_J;
                t_wr[n_rows]  = 1'b0;
            end
            "NA":    t_wr[n_rows] = 1'b0;   // Illegal word with no strobes
            default: ;                      // I arithmetic
        endcase
        n_rows++;
    endtask

    task automatic build_table();
        t_mnemonic  br_op [6] = '{OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU};
        logic [2:0] br_f3 [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
        int b;
        int f;
        add_row("add",    32'h0000_0033, 2'b00, OP_ADD,   ALU_ADD, 0, 0, "R");
        add_row("sub",    32'h4000_0033, 2'b00, OP_SUB,   ALU_SUB, 0, 0, "R");
        add_row("sll",    32'h0000_1033, 2'b00, OP_SLL,   ALU_SLL, 0, 0, "R");
        add_row("slt",    32'h0000_2033, 2'b00, OP_SLT,   ALU_SLT, 1, 0, "R");
        add_row("sltu",   32'h0000_3033, 2'b00, OP_SLTU,  ALU_SLT, 0, 0, "R");
        add_row("xor",    32'h0000_4033, 2'b00, OP_XOR,   ALU_XOR, 0, 0, "R");
        add_row("sra",    32'h4000_5033, 2'b00, OP_SRA,   ALU_SRA, 0, 0, "R");
        add_row("or",     32'h0000_6033, 2'b00, OP_OR,    ALU_OR,  0, 0, "R");
        add_row("and",    32'h0000_7033, 2'b00, OP_AND,   ALU_AND, 0, 0, "R");
        add_row("addi",   32'h0000_0013, 2'b00, OP_ADDI,  ALU_ADD, 0, 0, "I");
        add_row("slti",   32'h0000_2013, 2'b00, OP_SLTI,  ALU_SLT, 1, 0, "I");
        add_row("sltiu",  32'h0000_3013, 2'b00, OP_SLTIU, ALU_SLT, 0, 0, "I");
        add_row("srai",   32'h4000_5013, 2'b00, OP_SRAI,  ALU_SRA, 0, 0, "I");
        add_row("lw",     32'h0000_2003, 2'b00, OP_LW,    ALU_ADD, 0, 0, "L");
        add_row("lbu",    32'h0000_4003, 2'b00, OP_LBU,   ALU_ADD, 0, 0, "L");
        add_row("sw",     32'h0000_2023, 2'b00, OP_SW,    ALU_ADD, 0, 0, "S");
        add_row("lui",    32'h0000_0037, 2'b00, OP_LUI,   ALU_ADD, 0, 0, "LUI");
        add_row("auipc",  32'h0000_0017, 2'b00, OP_AUIPC, ALU_ADD, 0, 0, "AUI");
        add_row("jal",    32'h0000_006f, 2'b00, OP_JAL,   ALU_ADD, 0, 1, "JAL");
        add_row("jalr",   32'h0000_0067, 2'b00, OP_JALR,  ALU_ADD, 0, 0, "JALR");
        add_row("ecall",  32'h0000_0073, 2'b00, OP_NA,    ALU_ADD, 0, 0, "NA");
        add_row("ld_f3_3", 32'h0000_3003, 2'b00, OP_NA,   ALU_ADD, 0, 0, "NA");
        // Every branch under all four flag combinations
        for (b = 0; b < 6; b++) begin
            for (f = 0; f < 4; f++) begin
                add_row($sformatf("%s_z%0d_s%0d", br_op[b].name(), f[1], f[0]),
                        32'h0000_0063 | {17'd0, br_f3[b], 12'd0},
                        f[1:0], br_op[b], (b < 2) ? ALU_SUB : ALU_SLT,
                        (br_op[b] == OP_BLT || br_op[b] == OP_BGE),
                        branch_taken(br_op[b], f[1], f[0]), "B");
            end
        end
    endtask

    task automatic send_word(input int idx, input int gap);
        logic [31:0] regs;
        int wait_cnt;
        take_bits(15, regs);
        instr_valid = 1'b0;
        repeat (gap) begin
            @(posedge clk);
            #1;
        end
        drv_idx     = idx;
        drv_rs1     = regs[4:0];
        drv_rs2     = regs[9:5];
        drv_rd      = regs[14:10];
        instruction = t_word[idx] | {7'd0, drv_rs2, drv_rs1, 3'd0, drv_rd, 7'd0};
        instr_valid = 1'b1;
        wait_cnt    = 0;
        @(negedge clk);
        while (!instr_ready && wait_cnt < WAIT_LIMIT) begin
            @(negedge clk);
            wait_cnt++;
        end
        if (!instr_ready) begin
            $display("Timeout waiting for instr_ready on row %s", t_name[idx]);
            timeouts++;
        end
        @(posedge clk);
        #1;
        instr_valid = 1'b0;
    endtask

    // ALU flags for the item in flight change just after the edge
    always @(posedge clk) begin
        #1;
        alu_zero = want_flags[1];
        alu_slt  = want_flags[0];
    end

    // Monitor samples mid-cycle when every output has settled
    always @(negedge clk) begin
        if (rst_n) begin
            if (instr_valid && instr_ready) begin
                q_idx.push_back(drv_idx);
                q_rs1.push_back(drv_rs1);
                q_rs2.push_back(drv_rs2);
                q_rd.push_back(drv_rd);
                acc_cnt++;
            end
            if (!instr_ready) saw_full = 1'b1;
            if (u_dut.pop) pop_cnt++;
            if (acc_cnt - pop_cnt > BUF_DEPTH) begin
                $display("More words in flight than buffer slots: %0d", acc_cnt - pop_cnt);
                other_errs++;
            end
            if (active && state == FETCH) begin
                if (path != t_path[cur]) begin
                    $display("ERR %s path: expected %s, actual %s", cur_name, t_path[cur], path);
                    mism_errs++;
                end
                if (rw_cnt != int'(t_wr[cur])) log_mismatch("reg_write count", t_wr[cur], rw_cnt);
                if (mw_cnt != int'(t_path[cur] == "DEM")) begin
                    log_mismatch("mem_write count", t_path[cur] == "DEM", mw_cnt);
                end
                active = 1'b0;
                done_cnt++;
            end
            case (state)
                DECODE: begin
                    if (q_idx.size() == 0) begin
                        $display("Sequencer reached DECODE with no accepted word pending");
                        other_errs++;
                    end else begin
                        cur        = q_idx.pop_front();
                        cur_name   = t_name[cur];
                        want_flags = t_flags[cur];
                        if (op !== t_op[cur]) log_mismatch("op", t_op[cur], op);
                        if (rs1 !== q_rs1[0]) log_mismatch("rs1", q_rs1[0], rs1);
                        if (rs2 !== q_rs2[0]) log_mismatch("rs2", q_rs2[0], rs2);
                        if (rd !== q_rd[0]) log_mismatch("rd", q_rd[0], rd);
                        if (pc_update !== 1'b1) log_mismatch("pc_update", 1, pc_update);
                        void'(q_rs1.pop_front());
                        void'(q_rs2.pop_front());
                        void'(q_rd.pop_front());
                        active = 1'b1;
                        path   = "D";
                        rw_cnt = 0;
                        mw_cnt = 0;
                    end
                end
                EXECUTE: begin
                    path = {path, "E"};
                    if (op !== t_op[cur]) log_mismatch("op", t_op[cur], op);
                    if (alu_ctrl !== t_alu[cur]) log_mismatch("alu_ctrl", t_alu[cur], alu_ctrl);
                    if (alu_signed !== t_sgn[cur]) log_mismatch("alu_signed", t_sgn[cur], alu_signed);
                    if (alu_src_a !== t_sa[cur]) log_mismatch("alu_src_a", t_sa[cur], alu_src_a);
                    if (alu_src_b !== t_sb[cur]) log_mismatch("alu_src_b", t_sb[cur], alu_src_b);
                    if (imm_src !== t_imm[cur]) log_mismatch("imm_src", t_imm[cur], imm_src);
                    if (result_src !== (t_path[cur] == "DEMW")) begin
                        log_mismatch("result_src", t_path[cur] == "DEMW", result_src);
                    end
                    if (pc_src !== t_pc[cur]) log_mismatch("pc_src", t_pc[cur], pc_src);
                end
                MEM: begin
                    path = {path, "M"};
                    if (mem_write) mw_cnt++;
                end
                WB: begin
                    path = {path, "W"};
                    if (reg_write) rw_cnt++;
                end
                default: ;
            endcase
            // Strobes stay low outside their own state
            if (state != DECODE && pc_update !== 1'b0) log_mismatch("pc_update", 0, pc_update);
            if (state != EXECUTE && pc_src !== 1'b0) log_mismatch("pc_src", 0, pc_src);
            if (state != MEM && mem_write !== 1'b0) log_mismatch("mem_write", 0, mem_write);
            if (state != WB && reg_write !== 1'b0) log_mismatch("reg_write", 0, reg_write);
        end
    end

    initial begin
        int pass_no;
        int i;
        int wait_cnt;
        logic [31:0] gap;
        clk         = 1'b0;
        rst_n       = 1'b0;
        instruction = '0;
        instr_valid = 1'b0;
        alu_zero    = 1'b0;
        alu_slt     = 1'b0;
        build_table();
        repeat (15) @(posedge clk);
        @(negedge clk);
        cur_name = "reset";
        if (state !== IDLE) log_mismatch("state", IDLE, state);
        if (reg_write !== 1'b0) log_mismatch("reg_write", 0, reg_write);
        if (mem_write !== 1'b0) log_mismatch("mem_write", 0, mem_write);
        if (pc_update !== 1'b0) log_mismatch("pc_update", 0, pc_update);
        if (pc_src !== 1'b0) log_mismatch("pc_src", 0, pc_src);
        if (instr_ready !== 1'b1) log_mismatch("instr_ready", 1, instr_ready);
        @(posedge clk);
        #1;
        rst_n = 1'b1;
        // First pass with random gaps and the second back to back
        for (pass_no = 0; pass_no < 2; pass_no++) begin
            for (i = 0; i < n_rows; i++) begin
                if (pass_no == 0) take_bits(2, gap);
                else gap = 0;
                send_word(i, gap);
            end
        end
        wait_cnt = 0;
        while (done_cnt < 2 * n_rows && wait_cnt < DRAIN_LIMIT) begin
            @(negedge clk);
            wait_cnt++;
        end
        if (done_cnt < 2 * n_rows) begin
            $display("Timeout waiting for the sequencer to retire all words");
            timeouts++;
        end
        if (!saw_full) begin
            $display("instr_ready never went low under back-to-back words");
            other_errs++;
        end
        total_errs = mism_errs + other_errs + timeouts + u_dut.u_seq.u_chk.fail_cnt;
        $display("Errors: mismatch %0d, other %0d, timeout %0d, assertion %0d",
                 mism_errs, other_errs, timeouts, u_dut.u_seq.u_chk.fail_cnt);
        if (total_errs == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: src/decode_buffer.sv
`timescale 1ns/1ps

module decode_buffer import rv_ctrl_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 push,
    input  t_mnemonic            push_op,
    input  logic [REG_IDX_W-1:0] push_rs1,
    input  logic [REG_IDX_W-1:0] push_rs2,
    input  logic [REG_IDX_W-1:0] push_rd,
    input  logic                 pop,
    output logic                 buf_valid,
    output t_mnemonic            head_op,
    output logic [REG_IDX_W-1:0] head_rs1,
    output logic [REG_IDX_W-1:0] head_rs2,
    output logic [REG_IDX_W-1:0] head_rd,
    output logic                 credit_return
);

    t_mnemonic            op_mem  [BUF_DEPTH];
    logic [REG_IDX_W-1:0] rs1_mem [BUF_DEPTH];
    logic [REG_IDX_W-1:0] rs2_mem [BUF_DEPTH];
    logic [REG_IDX_W-1:0] rd_mem  [BUF_DEPTH];

    logic [PTR_W-1:0]     wr_ptr;
    logic [PTR_W-1:0]     rd_ptr;
    logic [PTR_W:0]       count;   // 0 to BUF_DEPTH
    logic                 do_pop;

    assign buf_valid     = (count != '0);
    assign do_pop        = pop && buf_valid;
    assign credit_return = do_pop;   // One credit back per item taken

    assign head_op  = op_mem[rd_ptr];
    assign head_rs1 = rs1_mem[rd_ptr];
    assign head_rs2 = rs2_mem[rd_ptr];
    assign head_rd  = rd_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;    // Pointers wrap at BUF_DEPTH
            if (do_pop) rd_ptr <= rd_ptr + 1'b1;
            case ({push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Push is never refused, the decoder's credits keep a slot free
    always_ff @(posedge clk) begin
        if (push) begin
            op_mem[wr_ptr]  <= push_op;
            rs1_mem[wr_ptr] <= push_rs1;
            rs2_mem[wr_ptr] <= push_rs2;
            rd_mem[wr_ptr]  <= push_rd;
        end
    end

endmodule

// File: src/instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder import rv_ctrl_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [INSTR_W-1:0]   instruction,
    input  logic                 instr_valid,
    input  logic                 credit_return,
    output logic                 instr_ready,
    output logic                 push,
    output t_mnemonic            push_op,
    output logic [REG_IDX_W-1:0] push_rs1,
    output logic [REG_IDX_W-1:0] push_rs2,
    output logic [REG_IDX_W-1:0] push_rd
);

    t_opcode             opcode;
    logic [2:0]          funct3;
    logic                funct7_b5;
    t_mnemonic           mnemonic;
    logic [CREDIT_W-1:0] credits;
    logic                accept;

    assign opcode    = t_opcode'(instruction[OPCODE_MSB:0]);
    assign funct3    = instruction[FUNCT3_LSB +: 3];
    assign funct7_b5 = instruction[FUNCT7_LSB + 5];   // SUB and SRA/SRAI select

    assign instr_ready = (credits != '0);   // One free slot is guaranteed per credit
    assign accept      = instr_valid && instr_ready;

    always_comb begin
        mnemonic = OP_NA;
        case (opcode)
            R_TYPE: begin
                case (funct3)
                    3'h0: mnemonic = funct7_b5 ? OP_SUB : OP_ADD;
                    3'h1: mnemonic = OP_SLL;
                    3'h2: mnemonic = OP_SLT;
                    3'h3: mnemonic = OP_SLTU;
                    3'h4: mnemonic = OP_XOR;
                    3'h5: mnemonic = funct7_b5 ? OP_SRA : OP_SRL;
                    3'h6: mnemonic = OP_OR;
                    default: mnemonic = OP_AND;
                endcase
            end
            I_TYPE: begin
                case (funct3)
                    3'h0: mnemonic = OP_ADDI;
                    3'h1: mnemonic = OP_SLLI;
                    3'h2: mnemonic = OP_SLTI;
                    3'h3: mnemonic = OP_SLTIU;
                    3'h4: mnemonic = OP_XORI;
                    3'h5: mnemonic = funct7_b5 ? OP_SRAI : OP_SRLI;
                    3'h6: mnemonic = OP_ORI;
                    default: mnemonic = OP_ANDI;
                endcase
            end
            I_LOAD_TYPE: begin
                case (funct3)
                    3'h0: mnemonic = OP_LB;
                    3'h1: mnemonic = OP_LH;
                    3'h2: mnemonic = OP_LW;
                    3'h4: mnemonic = OP_LBU;
                    3'h5: mnemonic = OP_LHU;
                    default: mnemonic = OP_NA;
                endcase
            end
            S_TYPE: begin
                case (funct3)
                    3'h0: mnemonic = OP_SB;
                    3'h1: mnemonic = OP_SH;
                    3'h2: mnemonic = OP_SW;
                    default: mnemonic = OP_NA;
                endcase
            end
            B_TYPE: begin
                case (funct3)
                    3'h0: mnemonic = OP_BEQ;
                    3'h1: mnemonic = OP_BNE;
                    3'h4: mnemonic = OP_BLT;
                    3'h5: mnemonic = OP_BGE;
                    3'h6: mnemonic = OP_BLTU;
                    3'h7: mnemonic = OP_BGEU;
                    default: mnemonic = OP_NA;
                endcase
            end
            I_JALR_TYPE: mnemonic = OP_JALR;
            U_LUI_TYPE:  mnemonic = OP_LUI;
            U_AUI_TYPE:  mnemonic = OP_AUIPC;
            J_TYPE:      mnemonic = OP_JAL;
            default:     mnemonic = OP_NA;   // SYSTEM and unknown opcodes
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            credits <= CREDIT_W'(BUF_DEPTH);
        end else begin
            case ({accept, credit_return})
                2'b10:   credits <= credits - 1'b1;   // Spent on acceptance
                2'b01:   credits <= credits + 1'b1;   // Returned by a pop
                default: credits <= credits;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            push <= 1'b0;
        end else begin
            push <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            push_op  <= mnemonic;
            push_rs1 <= instruction[RS1_LSB +: REG_IDX_W];
            push_rs2 <= instruction[RS2_LSB +: REG_IDX_W];
            push_rd  <= instruction[RD_LSB +: REG_IDX_W];
        end
    end

endmodule

// File: src/multicycle_seq.sv
`timescale 1ns/1ps

module multicycle_seq import rv_ctrl_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 buf_valid,
    input  t_mnemonic            head_op,
    input  logic [REG_IDX_W-1:0] head_rs1,
    input  logic [REG_IDX_W-1:0] head_rs2,
    input  logic [REG_IDX_W-1:0] head_rd,
    input  logic                 alu_zero,
    input  logic                 alu_slt,
    output logic                 pop,
    output t_decode_state        state,
    output t_mnemonic            op,
    output logic [REG_IDX_W-1:0] rs1,
    output logic [REG_IDX_W-1:0] rs2,
    output logic [REG_IDX_W-1:0] rd,
    output t_alu_op              alu_ctrl,
    output logic                 alu_signed,
    output t_src_a               alu_src_a,
    output t_src_b               alu_src_b,
    output t_imm_kind            imm_src,
    output logic                 result_src,
    output logic                 pc_src,
    output logic                 pc_update,
    output logic                 mem_write,
    output logic                 reg_write
);

    t_decode_state next_state;
    logic          wr_reg;    // Ungated register write
    logic          wr_mem;    // Ungated memory write
    logic          taken;     // Branch or jump resolved as taken
    logic          is_load;
    logic          is_store;
    logic          is_flow;   // Branches and JAL return to FETCH from EXECUTE

    assign pop = (state == FETCH) && buf_valid;

    always_comb begin
        next_state = state;
        case (state)
            IDLE:    next_state = FETCH;
            FETCH:   next_state = buf_valid ? DECODE : FETCH;
            DECODE:  next_state = EXECUTE;
            EXECUTE: begin
                if (is_load || is_store) next_state = MEM;
                else if (is_flow)        next_state = FETCH;
                else                     next_state = WB;   // JALR and OP_NA too
            end
            MEM:     next_state = is_store ? FETCH : WB;
            WB:      next_state = FETCH;
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= IDLE;
            op    <= OP_NA;
        end else begin
            state <= next_state;
            if (pop) op <= head_op;   // Held until the next pop
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            rs1 <= head_rs1;
            rs2 <= head_rs2;
            rd  <= head_rd;
        end
    end

    // ALU operation per mnemonic
    always_comb begin
        case (op)
            OP_SUB, OP_BEQ, OP_BNE:                       alu_ctrl = ALU_SUB;
            OP_SLL, OP_SLLI:                              alu_ctrl = ALU_SLL;
            OP_SLT, OP_SLTU, OP_SLTI, OP_SLTIU,
            OP_BLT, OP_BGE, OP_BLTU, OP_BGEU:             alu_ctrl = ALU_SLT;
            OP_XOR, OP_XORI:                              alu_ctrl = ALU_XOR;
            OP_SRL, OP_SRLI:                              alu_ctrl = ALU_SRL;
            OP_SRA, OP_SRAI:                              alu_ctrl = ALU_SRA;
            OP_OR, OP_ORI:                                alu_ctrl = ALU_OR;
            OP_AND, OP_ANDI:                              alu_ctrl = ALU_AND;
            default:                                      alu_ctrl = ALU_ADD;
        endcase
    end

    assign alu_signed = (op inside {OP_SLT, OP_SLTI, OP_BLT, OP_BGE});

    // Operand sources, immediate kind and write enables per class
    always_comb begin
        alu_src_a  = SRC_A_REG;
        alu_src_b  = SRC_B_IMM;
        imm_src    = IMM_I;
        result_src = 1'b0;
        wr_reg     = 1'b0;
        wr_mem     = 1'b0;
        is_load    = 1'b0;
        is_store   = 1'b0;
        is_flow    = 1'b0;
        taken      = 1'b0;
        case (op)
            OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU,
            OP_XOR, OP_SRL, OP_SRA, OP_OR, OP_AND: begin
                alu_src_b = SRC_B_REG;
                wr_reg    = 1'b1;
            end
            OP_ADDI, OP_SLLI, OP_SLTI, OP_SLTIU, OP_XORI,
            OP_SRLI, OP_SRAI, OP_ORI, OP_ANDI: begin
                wr_reg = 1'b1;
            end
            OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU: begin
                result_src = 1'b1;   // Write back memory data
                wr_reg     = 1'b1;
                is_load    = 1'b1;
            end
            OP_SB, OP_SH, OP_SW: begin
                imm_src  = IMM_S;
                wr_mem   = 1'b1;
                is_store = 1'b1;
            end
            OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU: begin
                alu_src_b = SRC_B_REG;
                imm_src   = IMM_B;
                is_flow   = 1'b1;
                case (op)
                    OP_BEQ:         taken = alu_zero;
                    OP_BNE:         taken = !alu_zero;
                    OP_BLT, OP_BLTU: taken = alu_slt;
                    default:        taken = !alu_slt;   // BGE and BGEU
                endcase
            end
            OP_JAL: begin
                alu_src_b = SRC_B_REG;
                imm_src   = IMM_J;
                is_flow   = 1'b1;
                taken     = 1'b1;
            end
            OP_JALR: begin
                alu_src_b = SRC_B_REG;
                imm_src   = IMM_J;
            end
            OP_LUI: begin
                imm_src = IMM_U;
                wr_reg  = 1'b1;
            end
            OP_AUIPC: begin
                alu_src_a = SRC_A_PC;
                imm_src   = IMM_U;
                wr_reg    = 1'b1;
            end
            default: begin
                imm_src = IMM_I;   // OP_NA keeps every strobe low
            end
        endcase
    end

    assign reg_write = wr_reg && (state == WB);
    assign mem_write = wr_mem && (state == MEM);
    assign pc_update = (state == DECODE);   // PC advances once per instruction
    assign pc_src    = taken && (state == EXECUTE);

endmodule

// File: src/rv_ctrl_pkg.sv
package rv_ctrl_pkg;

    localparam int INSTR_W    = 32;
    localparam int REG_IDX_W  = 5;

    localparam int OPCODE_MSB = 6;
    localparam int RD_LSB     = 7;
    localparam int FUNCT3_LSB = 12;
    localparam int RS1_LSB    = 15;
    localparam int RS2_LSB    = 20;
    localparam int FUNCT7_LSB = 25;

    localparam int BUF_DEPTH  = 4;
    localparam int CREDIT_W   = 3;   // Holds 0 to BUF_DEPTH
    localparam int PTR_W      = 2;

    // Major opcodes of the kept RV32I subset
    typedef enum logic [6:0] {
        R_TYPE      = 7'b0110011,
        I_TYPE      = 7'b0010011,
        I_LOAD_TYPE = 7'b0000011,
        I_JALR_TYPE = 7'b1100111,
        S_TYPE      = 7'b0100011,
        B_TYPE      = 7'b1100011,
        U_LUI_TYPE  = 7'b0110111,
        U_AUI_TYPE  = 7'b0010111,
        J_TYPE      = 7'b1101111
    } t_opcode;

    typedef enum logic [5:0] {
        OP_NA,       // Illegal or unsupported word
        OP_ADD,
        OP_SUB,
        OP_SLL,
        OP_SLT,
        OP_SLTU,
        OP_XOR,
        OP_SRL,
        OP_SRA,
        OP_OR,
        OP_AND,
        OP_ADDI,
        OP_SLLI,
        OP_SLTI,
        OP_SLTIU,
        OP_XORI,
        OP_SRLI,
        OP_SRAI,
        OP_ORI,
        OP_ANDI,
        OP_LB,
        OP_LH,
        OP_LW,
        OP_LBU,
        OP_LHU,
        OP_SB,
        OP_SH,
        OP_SW,
        OP_BEQ,
        OP_BNE,
        OP_BLT,
        OP_BGE,
        OP_BLTU,
        OP_BGEU,
        OP_JAL,
        OP_JALR,
        OP_LUI,
        OP_AUIPC
    } t_mnemonic;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } t_alu_op;

    typedef enum logic [2:0] {
        IDLE,
        FETCH,
        DECODE,
        EXECUTE,
        MEM,
        WB
    } t_decode_state;

    typedef enum logic [2:0] {
        IMM_I = 3'd0,
        IMM_S = 3'd1,
        IMM_B = 3'd2,
        IMM_J = 3'd3,
        IMM_U = 3'd4
    } t_imm_kind;

    typedef enum logic [1:0] {
        SRC_A_REG = 2'd1,
        SRC_A_PC  = 2'd2
    } t_src_a;

    typedef enum logic [1:0] {
        SRC_B_REG = 2'd0,
        SRC_B_IMM = 2'd2
    } t_src_b;

endpackage

// File: src/rv_ctrl_top.sv
`timescale 1ns/1ps

module rv_ctrl_top import rv_ctrl_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [INSTR_W-1:0]   instruction,
    input  logic                 instr_valid,
    input  logic                 alu_zero,
    input  logic                 alu_slt,
    output logic                 instr_ready,
    output t_decode_state        state,
    output t_mnemonic            op,
    output logic [REG_IDX_W-1:0] rs1,
    output logic [REG_IDX_W-1:0] rs2,
    output logic [REG_IDX_W-1:0] rd,
    output t_alu_op              alu_ctrl,
    output logic                 alu_signed,
    output t_src_a               alu_src_a,
    output t_src_b               alu_src_b,
    output t_imm_kind            imm_src,
    output logic                 result_src,
    output logic                 pc_src,
    output logic                 pc_update,
    output logic                 mem_write,
    output logic                 reg_write
);

    logic                 push;
    t_mnemonic            push_op;
    logic [REG_IDX_W-1:0] push_rs1;
    logic [REG_IDX_W-1:0] push_rs2;
    logic [REG_IDX_W-1:0] push_rd;
    logic                 credit_return;
    logic                 pop;
    logic                 buf_valid;
    t_mnemonic            head_op;
    logic [REG_IDX_W-1:0] head_rs1;
    logic [REG_IDX_W-1:0] head_rs2;
    logic [REG_IDX_W-1:0] head_rd;

    instr_decoder u_decoder (
        .clk, .rst_n, .instruction, .instr_valid, .credit_return,
        .instr_ready, .push, .push_op, .push_rs1, .push_rs2, .push_rd
    );

    decode_buffer u_buffer (
        .clk, .rst_n, .push, .push_op, .push_rs1, .push_rs2, .push_rd, .pop,
        .buf_valid, .head_op, .head_rs1, .head_rs2, .head_rd, .credit_return
    );

    multicycle_seq u_seq (
        .clk, .rst_n, .buf_valid, .head_op, .head_rs1, .head_rs2, .head_rd,
        .alu_zero, .alu_slt, .pop, .state, .op, .rs1, .rs2, .rd,
        .alu_ctrl, .alu_signed, .alu_src_a, .alu_src_b, .imm_src, .result_src,
        .pc_src, .pc_update, .mem_write, .reg_write
    );

endmodule
